// ==== sim.f ====
hdl/board_video_pkg.sv
hdl/video_sync_if.sv
hdl/video_capture.sv
hdl/channel_bw_filter.sv
hdl/video_out_stage.sv
hdl/board_video.sv
testbench/tb_clock_gen.sv
testbench/board_video_sva.sv
testbench/tb_board_video.sv

// ==== Makefile ====
# Verilator build and run for the board video testbench

VERILATOR ?= verilator
TOP       ?= tb_board_video
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Test failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_board_video.sv ====
// Testbench for board_video: random stimulus, reference model, checker and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_board_video;

    localparam int COLORW = board_video_pkg::COLORW_DEFAULT;
    localparam int FW     = COLORW + 1;

    // Pixel enable patterns
    localparam int CEN_RANDOM = 0;
    localparam int CEN_ALWAYS = 1;
    localparam int CEN_BURST  = 2;

    // Bandwidth enable patterns
    localparam int BW_LOW    = 0;
    localparam int BW_HIGH   = 1;
    localparam int BW_BLOCKS = 2;
    localparam int BW_RANDOM = 3;

    // Four phases of 500 pixels, about 2 cycles per pixel, generous margin
    localparam int PHASE_PIXELS   = 500;
    localparam int PIXELS_TOTAL   = 4 * PHASE_PIXELS;
    localparam int TIMEOUT_CYCLES = PIXELS_TOTAL * 5;

    typedef struct packed {
        logic [COLORW-1:0] r;
        logic [COLORW-1:0] g;
        logic [COLORW-1:0] b;
        logic              hs;
        logic              vs;
        logic              lhbl;
        logic              lvbl;
        logic              bw_en;
    } pix_t;

    logic              clk_sys;
    logic              reset;
    logic              pxl_cen;
    logic [COLORW-1:0] game_r;
    logic [COLORW-1:0] game_g;
    logic [COLORW-1:0] game_b;
    logic              hs;
    logic              vs;
    logic              lhbl;
    logic              lvbl;
    logic              bw_en;

    board_video_pkg::vga_color_t scan2x_r;
    board_video_pkg::vga_color_t scan2x_g;
    board_video_pkg::vga_color_t scan2x_b;
    logic                        scan2x_hs;
    logic                        scan2x_vs;
    logic                        scan2x_de;

    // Expected outputs, updated on pixel edges only
    board_video_pkg::vga_color_t exp_r;
    board_video_pkg::vga_color_t exp_g;
    board_video_pkg::vga_color_t exp_b;
    logic                        exp_hs;
    logic                        exp_vs;
    logic                        exp_de;

    // Samples of the last four pixel edges, oldest first
    pix_t hist[$];

    int error_count = 0;
    int cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(100)) u_clk (
        .clk ( clk_sys )
    );

    board_video #(.COLORW(COLORW)) UUT (
        .clk_sys   ( clk_sys   ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .game_r    ( game_r    ),
        .game_g    ( game_g    ),
        .game_b    ( game_b    ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .bw_en     ( bw_en     ),
        .scan2x_r  ( scan2x_r  ),
        .scan2x_g  ( scan2x_g  ),
        .scan2x_b  ( scan2x_b  ),
        .scan2x_hs ( scan2x_hs ),
        .scan2x_vs ( scan2x_vs ),
        .scan2x_de ( scan2x_de )
    );

    // Filter then widen: the value is laid end to end until 8 bits are covered,
    // and the surplus low bits are dropped
    function automatic board_video_pkg::vga_color_t ref_color(
        input logic [COLORW-1:0] cur,
        input logic [COLORW-1:0] prev,
        input logic              bw
    );
        int v;
        int acc;
        int filled;
        if (bw) begin
            v = int'(cur) + int'(prev);
        end else begin
            v = 2 * int'(cur);
        end
        acc    = 0;
        filled = 0;
        while (filled < board_video_pkg::VGA_BITS) begin
            acc    = (acc << FW) | v;
            filled = filled + FW;
        end
        return board_video_pkg::vga_color_t'(acc >> (filled - board_video_pkg::VGA_BITS));
    endfunction

    task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL at %0d ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic drive_random_video();
        game_r = COLORW'($urandom);
        game_g = COLORW'($urandom);
        game_b = COLORW'($urandom);
        hs     = ($urandom % 2) == 0;
        vs     = ($urandom % 16) == 0;
        // Mostly in the active area
        lhbl   = ($urandom % 8) != 0;
        lvbl   = ($urandom % 8) != 0;
    endtask

    task automatic apply_reset();
        @(negedge clk_sys);
        reset   = 1'b1;
        pxl_cen = 1'b1;
        drive_random_video();
        @(negedge clk_sys);
        drive_random_video();
        @(negedge clk_sys);
        reset = 1'b0;
    endtask

    task automatic run_phase(input int n_pixels, input int cen_mode, input int bw_mode);
        int pixels;
        int block_left;
        pixels     = 0;
        block_left = 0;
        while (pixels < n_pixels) begin
            @(negedge clk_sys);
            drive_random_video();
            case (cen_mode)
                CEN_ALWAYS: pxl_cen = 1'b1;
                CEN_BURST: begin
                    if (($urandom % 4) == 0) begin
                        pxl_cen = ~pxl_cen;
                    end
                end
                default: pxl_cen = ($urandom % 2) == 0;
            endcase
            case (bw_mode)
                BW_LOW:  bw_en = 1'b0;
                BW_HIGH: bw_en = 1'b1;
                BW_BLOCKS: begin
                    if (block_left == 0) begin
                        bw_en      = ~bw_en;
                        block_left = 1 + int'($urandom % 8);
                    end else begin
                        block_left--;
                    end
                end
                default: bw_en = ($urandom % 2) == 0;
            endcase
            if (pxl_cen) begin
                pixels++;
            end
        end
    endtask

    initial begin : stimulus
        int seed_value;
        seed_value = $urandom(32'h53d5);
        reset   = 1'b1;
        pxl_cen = 1'b0;
        bw_en   = 1'b0;
        game_r  = '0;
        game_g  = '0;
        game_b  = '0;
        hs      = 1'b0;
        vs      = 1'b0;
        lhbl    = 1'b0;
        lvbl    = 1'b0;
        repeat (2) @(negedge clk_sys);
        reset = 1'b0;

        run_phase(PHASE_PIXELS, CEN_RANDOM, BW_LOW);
        apply_reset();
        run_phase(PHASE_PIXELS, CEN_ALWAYS, BW_HIGH);
        run_phase(PHASE_PIXELS, CEN_BURST, BW_BLOCKS);
        apply_reset();
        run_phase(PHASE_PIXELS, CEN_RANDOM, BW_RANDOM);

        // Flush the last pixels, then idle with the outputs held
        @(negedge clk_sys);
        pxl_cen = 1'b1;
        repeat (2) @(negedge clk_sys);
        pxl_cen = 1'b0;
        repeat (4) @(negedge clk_sys);

        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Model update at each rising edge, output check half a cycle later
    always begin : compare_proc
        pix_t s;
        pix_t zero_pix;
        pix_t cur;
        pix_t old;
        pix_t ctl;
        zero_pix = '0;
        @(posedge clk_sys);
        s.r     = game_r;
        s.g     = game_g;
        s.b     = game_b;
        s.hs    = hs;
        s.vs    = vs;
        s.lhbl  = lhbl;
        s.lvbl  = lvbl;
        s.bw_en = bw_en;
        if (reset) begin
            hist.delete();
            repeat (4) hist.push_back(zero_pix);
            exp_r  = '0;
            exp_g  = '0;
            exp_b  = '0;
            exp_hs = 1'b0;
            exp_vs = 1'b0;
            exp_de = 1'b0;
        end else if (pxl_cen) begin
            hist.push_back(s);
            void'(hist.pop_front());
            // Colors and syncs from edge n-2, bw_en from edge n-1
            old    = hist[0];
            cur    = hist[1];
            ctl    = hist[2];
            exp_r  = ref_color(cur.r, old.r, ctl.bw_en);
            exp_g  = ref_color(cur.g, old.g, ctl.bw_en);
            exp_b  = ref_color(cur.b, old.b, ctl.bw_en);
            exp_hs = cur.hs;
            exp_vs = cur.vs;
            exp_de = cur.lhbl & cur.lvbl;
        end
        @(negedge clk_sys);
        check_value("scan2x_r", scan2x_r, exp_r);
        check_value("scan2x_g", scan2x_g, exp_g);
        check_value("scan2x_b", scan2x_b, exp_b);
        check_value("scan2x_hs", {7'd0, scan2x_hs}, {7'd0, exp_hs});
        check_value("scan2x_vs", {7'd0, scan2x_vs}, {7'd0, exp_vs});
        check_value("scan2x_de", {7'd0, scan2x_de}, {7'd0, exp_de});
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: the test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/board_video_sva.sv ====
// Concurrent assertions on the board video top level, attached with bind
`timescale 1ns/1ps
`default_nettype none

module board_video_sva (
    input wire                                 clk_sys,
    input wire                                 reset,
    input wire                                 pxl_cen,
    input wire                                 lhbl,
    input wire                                 lvbl,
    input wire [board_video_pkg::VGA_BITS-1:0] scan2x_r,
    input wire [board_video_pkg::VGA_BITS-1:0] scan2x_g,
    input wire [board_video_pkg::VGA_BITS-1:0] scan2x_b,
    input wire                                 scan2x_hs,
    input wire                                 scan2x_vs,
    input wire                                 scan2x_de
);

    // Goes high after the first clock edge, so $past has a real history
    logic started = 1'b0;

    // AND of the blanking inputs at the last three pixel edges, newest in bit 0
    logic [2:0] blank_pipe;

    logic [3*board_video_pkg::VGA_BITS+2:0] outs;

    assign outs = {scan2x_r, scan2x_g, scan2x_b, scan2x_hs, scan2x_vs, scan2x_de};

    always @(posedge clk_sys) begin
        started <= 1'b1;
        if (reset) begin
            blank_pipe <= '0;
        end else if (pxl_cen) begin
            blank_pipe <= {blank_pipe[1:0], lhbl & lvbl};
        end
    end

    hold_between_pixels: assert property (@(posedge clk_sys) disable iff (reset)
        (started && !$past(pxl_cen) && !$past(reset)) |-> $stable(outs))
        else $error("outputs changed on a clock edge without pxl_cen");

    de_matches_blanking: assert property (@(posedge clk_sys) disable iff (reset)
        started |-> (scan2x_de == blank_pipe[2]))
        else $error("scan2x_de does not match blanking from two pixel edges earlier");

    zero_after_reset: assert property (@(posedge clk_sys)
        (started && $past(reset)) |-> (outs == '0))
        else $error("outputs not cleared in the cycle after reset");

endmodule

bind board_video board_video_sva u_sva (
    .clk_sys   ( clk_sys   ),
    .reset     ( reset     ),
    .pxl_cen   ( pxl_cen   ),
    .lhbl      ( lhbl      ),
    .lvbl      ( lvbl      ),
    .scan2x_r  ( scan2x_r  ),
    .scan2x_g  ( scan2x_g  ),
    .scan2x_b  ( scan2x_b  ),
    .scan2x_hs ( scan2x_hs ),
    .scan2x_vs ( scan2x_vs ),
    .scan2x_de ( scan2x_de )
);

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Free-running clock source for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period high, half period low
    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== hdl/board_video.sv ====
// Top level of the board video path with the per-channel filter loop
`timescale 1ns/1ps
`default_nettype none

module board_video #(
    parameter int COLORW = board_video_pkg::COLORW_DEFAULT
) (
    input  wire                         clk_sys,
    input  wire                         reset,
    input  wire                         pxl_cen,

    // Game video
    input  wire    [COLORW-1:0]         game_r,
    input  wire    [COLORW-1:0]         game_g,
    input  wire    [COLORW-1:0]         game_b,
    input  wire                         hs,
    input  wire                         vs,
    input  wire                         lhbl,
    input  wire                         lvbl,

    // Analog bandwidth emulation on/off
    input  wire                         bw_en,

    // Scan doubler side
    output board_video_pkg::vga_color_t scan2x_r,
    output board_video_pkg::vga_color_t scan2x_g,
    output board_video_pkg::vga_color_t scan2x_b,
    output logic                        scan2x_hs,
    output logic                        scan2x_vs,
    output logic                        scan2x_de
);

    wire [COLORW-1:0] chan     [board_video_pkg::NUM_CHANNELS];
    wire [COLORW:0]   filtered [board_video_pkg::NUM_CHANNELS];

    video_sync_if u_sync_if ();

    video_capture #(.COLORW(COLORW)) u_capture (
        .clk_sys ( clk_sys   ),
        .reset   ( reset     ),
        .pxl_cen ( pxl_cen   ),
        .game_r  ( game_r    ),
        .game_g  ( game_g    ),
        .game_b  ( game_b    ),
        .hs      ( hs        ),
        .vs      ( vs        ),
        .lhbl    ( lhbl      ),
        .lvbl    ( lvbl      ),
        .sync    ( u_sync_if ),
        .chan    ( chan      )
    );

    // Same filter on every colour
    for (genvar i = 0; i < board_video_pkg::NUM_CHANNELS; i++) begin : gen_chan
        channel_bw_filter #(.COLORW(COLORW)) u_filter (
            .clk_sys  ( clk_sys     ),
            .reset    ( reset       ),
            .pxl_cen  ( pxl_cen     ),
            .bw_en    ( bw_en       ),
            .sample   ( chan[i]     ),
            .filtered ( filtered[i] )
        );
    end

    video_out_stage #(.COLORW(COLORW)) u_out (
        .clk_sys   ( clk_sys   ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .sync      ( u_sync_if ),
        .filtered  ( filtered  ),
        .scan2x_r  ( scan2x_r  ),
        .scan2x_g  ( scan2x_g  ),
        .scan2x_b  ( scan2x_b  ),
        .scan2x_hs ( scan2x_hs ),
        .scan2x_vs ( scan2x_vs ),
        .scan2x_de ( scan2x_de )
    );

endmodule

`default_nettype wire

// ==== hdl/video_out_stage.sv ====
// Output stage: colour widening to 8 bits, sync alignment and data enable
`timescale 1ns/1ps
`default_nettype none

module video_out_stage #(
    parameter int COLORW = 4
) (
    input  wire                        clk_sys,
    input  wire                        reset,
    input  wire                        pxl_cen,

    // Syncs straight from the capture stage
    video_sync_if.sink                 sync,

    // Filter outputs, ordered r, g, b
    input  wire [COLORW:0]             filtered [board_video_pkg::NUM_CHANNELS],

    output board_video_pkg::vga_color_t scan2x_r,
    output board_video_pkg::vga_color_t scan2x_g,
    output board_video_pkg::vga_color_t scan2x_b,
    output logic                       scan2x_hs,
    output logic                       scan2x_vs,
    output logic                       scan2x_de
);

    localparam int FW = COLORW + 1;

    board_video_pkg::sync_t sync_dly;

    // Repeat the value from its MSB down until the output is full,
    // so full scale on the input maps to full scale on the output
    function automatic board_video_pkg::vga_color_t widen(input logic [FW-1:0] a);
        board_video_pkg::vga_color_t w;
        w = '0;
        for (int i = 0; i < board_video_pkg::VGA_BITS; i++) begin
            w[board_video_pkg::VGA_BITS-1-i] = a[FW-1-(i % FW)];
        end
        return w;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            sync_dly  <= '0;
            scan2x_r  <= '0;
            scan2x_g  <= '0;
            scan2x_b  <= '0;
            scan2x_hs <= 1'b0;
            scan2x_vs <= 1'b0;
            scan2x_de <= 1'b0;
        end else if (pxl_cen) begin
            // One pixel of delay matches the filter register
            sync_dly  <= {sync.hs, sync.vs, sync.lhbl, sync.lvbl};
            scan2x_r  <= widen(filtered[0]);
            scan2x_g  <= widen(filtered[1]);
            scan2x_b  <= widen(filtered[2]);
            scan2x_hs <= sync_dly[3];
            scan2x_vs <= sync_dly[2];
            // Active area only when neither blanking is asserted
            scan2x_de <= sync_dly[1] & sync_dly[0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/channel_bw_filter.sv ====
// Bandwidth filter for one colour channel, mimicking a slow analog wire
`timescale 1ns/1ps
`default_nettype none

module channel_bw_filter #(
    parameter int COLORW = 4
) (
    input  wire               clk_sys,
    input  wire               reset,
    input  wire               pxl_cen,
    input  wire               bw_en,
    input  wire  [COLORW-1:0] sample,
    output logic [COLORW:0]   filtered
);

    logic [COLORW-1:0] prev;
    logic [COLORW:0]   sum;
    logic [COLORW:0]   dbl;

    // Two-tap average without the divide, one extra bit holds the carry
    assign sum = {1'b0, sample} + {1'b0, prev};

    // Bypass path keeps the same scale as the sum
    assign dbl = {sample, 1'b0};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            prev     <= '0;
            filtered <= '0;
        end else if (pxl_cen) begin
            // History follows the input even while the filter is bypassed
            prev     <= sample;
            filtered <= bw_en ? sum : dbl;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/video_capture.sv ====
// Input capture stage for game colour and sync signals
`timescale 1ns/1ps
`default_nettype none

module video_capture #(
    parameter int COLORW = 4
) (
    input  wire                 clk_sys,
    input  wire                 reset,
    input  wire                 pxl_cen,

    // Game video
    input  wire    [COLORW-1:0] game_r,
    input  wire    [COLORW-1:0] game_g,
    input  wire    [COLORW-1:0] game_b,
    input  wire                 hs,
    input  wire                 vs,
    input  wire                 lhbl,
    input  wire                 lvbl,

    // Registered syncs towards the output stage
    video_sync_if.capture       sync,

    // One sample per filter, ordered r, g, b
    output logic   [COLORW-1:0] chan [board_video_pkg::NUM_CHANNELS]
);

    logic [COLORW-1:0] r_q;
    logic [COLORW-1:0] g_q;
    logic [COLORW-1:0] b_q;

    // Game outputs may move between enables, so hold them here
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            r_q       <= '0;
            g_q       <= '0;
            b_q       <= '0;
            sync.hs   <= 1'b0;
            sync.vs   <= 1'b0;
            sync.lhbl <= 1'b0;
            sync.lvbl <= 1'b0;
        end else if (pxl_cen) begin
            r_q       <= game_r;
            g_q       <= game_g;
            b_q       <= game_b;
            sync.hs   <= hs;
            sync.vs   <= vs;
            sync.lhbl <= lhbl;
            sync.lvbl <= lvbl;
        end
    end

    // Channel order used by the filter loop
    assign chan[0] = r_q;
    assign chan[1] = g_q;
    assign chan[2] = b_q;

endmodule

`default_nettype wire

// ==== hdl/video_sync_if.sv ====
// Interface for the sync and blanking levels passed between video stages
`timescale 1ns/1ps
`default_nettype none

interface video_sync_if;

    // Sync pulses as produced by the game
    logic hs;
    logic vs;

    // Blanking, high while the beam is in the active area
    logic lhbl;
    logic lvbl;

    // Capture stage owns the levels
    modport capture (
        output hs,
        output vs,
        output lhbl,
        output lvbl
    );

    // Output stage only reads them
    modport sink (
        input hs,
        input vs,
        input lhbl,
        input lvbl
    );

endinterface

`default_nettype wire

// ==== hdl/board_video_pkg.sv ====
// Package with the constants and types shared along the video path
`default_nettype none

package board_video_pkg;

    // Game side colour depth, one channel
    localparam int COLORW_DEFAULT = 4;

    // Red, green and blue
    localparam int NUM_CHANNELS = 3;

    // Colour depth on the scan doubler outputs
    localparam int VGA_BITS = 8;

    // One output colour channel
    typedef logic [VGA_BITS-1:0] vga_color_t;

    // Packed syncs, MSB first: hs, vs, lhbl, lvbl
    // Used to delay the syncs by a whole pixel in one register
    typedef logic [3:0] sync_t;

endpackage

`default_nettype wire
